// File: fas_params.svh
//*************************************************
// FIR and frame assembly parameters
// Global widths and sizes shared by the filter,
// the frame buffer, the package and the testbench
//*************************************************
`ifndef FAS_PARAMS_SVH
`define FAS_PARAMS_SVH

// Width of one input or filtered sample
`define FAS_SAMPLE_W 16

// Number of filter taps and coefficients
`define FAS_TAPS 32

// Samples collected into one output frame
`define FAS_FRAME_LEN 16

// Width of one signed filter coefficient
`define FAS_COEFF_W 16

// Accumulator width, wide enough for 32 full-scale products
`define FAS_ACC_W 40

// Output slice of the accumulator, sign bit is prepended above FAS_OUT_MSB
`define FAS_OUT_LSB 16
`define FAS_OUT_MSB 30

`endif

// File: fir_coeffs.svh
//*************************************************
// FIR coefficient table
// 32 symmetric low-pass taps, sum close to unity
// gain after the output slice
// Include inside a module body after the package
//*************************************************

// Element k weights the sample that is k samples old
localparam fas_pkg::coeff_t fir_coeff [`FAS_TAPS] = '{
  -16'sd80,    // Tap 0 weights the newest sample
  -16'sd120,
  -16'sd150,
  -16'sd130,
  -16'sd40,
  16'sd150,
  16'sd440,
  16'sd800,
  16'sd1200,
  16'sd1600,
  16'sd2500,
  16'sd3400,
  16'sd4300,
  16'sd5100,
  16'sd5700,
  16'sd6000,   // Centre pair of the symmetric response
  16'sd6000,
  16'sd5700,
  16'sd5100,
  16'sd4300,
  16'sd3400,
  16'sd2500,
  16'sd1600,
  16'sd1200,
  16'sd800,
  16'sd440,
  16'sd150,
  -16'sd40,
  -16'sd130,
  -16'sd150,
  -16'sd120,
  -16'sd80     // Tap 31 weights the oldest sample
};

// File: fas_pkg.sv
//*************************************************
// FIR and frame assembly types
// Sample, coefficient, accumulator and frame types
// for the filter chain
//*************************************************
`default_nettype none

`include "fas_params.svh"

package fas_pkg;

  // Signed filter input and output sample
  typedef logic signed [`FAS_SAMPLE_W-1:0] sample_t;

  // Signed filter coefficient
  typedef logic signed [`FAS_COEFF_W-1:0] coeff_t;

  // Signed sum-of-products accumulator
  typedef logic signed [`FAS_ACC_W-1:0] acc_t;

  // One frame of filtered samples
  // Index 0 is the oldest sample of the frame
  typedef struct packed {
    sample_t [`FAS_FRAME_LEN-1:0] samples;  // 16 samples, 256 bits in all
  } frame_t;

endpackage

`default_nettype wire

// File: fir_filter.sv
//*************************************************
// 32-tap FIR filter
// Shifts accepted samples into a tap line, forms
// the sum of products and slices it into a one-deep
// output register under valid/ready handshaking
//*************************************************
`timescale 1ns/1ps
`default_nettype none

`include "fas_params.svh"

module fir_filter (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  fas_pkg::sample_t in_data,
  output logic             in_ready,
  output logic             fir_valid,
  output fas_pkg::sample_t fir_data,
  input  logic             fir_ready
);

  import fas_pkg::*;

  `include "fir_coeffs.svh"

  localparam int TAPS  = `FAS_TAPS;
  localparam int CNT_W = $clog2(TAPS);

  sample_t          taps     [TAPS];  // Tap line, index 0 holds the newest sample
  sample_t          taps_nxt [TAPS];  // Tap line after the current sample shifts in
  acc_t             acc_nxt;          // Sum of products over the shifted tap line
  logic [CNT_W-1:0] warm_cnt;         // Samples accepted since reset, saturates at 31
  logic             warm;             // Tap line holds 31 real samples already
  logic             accept;           // Input handshake completes this cycle

  // Output register can take a new result when empty or being drained
  assign in_ready = !fir_valid || fir_ready;
  assign accept   = in_valid && in_ready;

  // The next accepted sample is the 32nd or later one
  assign warm = (warm_cnt == CNT_W'(TAPS - 1));

  // New sample enters at tap 0 and every older one moves down by one
  always_comb begin
    taps_nxt[0] = in_data;
    for (int k = 1; k < TAPS; k++) begin
      taps_nxt[k] = taps[k-1];
    end
  end

  // Products are formed on the shifted line so the result belongs
  // to the sample accepted at this edge
  always_comb begin
    acc_nxt = '0;
    for (int k = 0; k < TAPS; k++) begin
      acc_nxt = acc_nxt + acc_t'(taps_nxt[k]) * acc_t'(fir_coeff[k]);  // Both sign extended
    end
  end

  // Tap line, warm-up counter and output valid
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      taps      <= '{default: '0};  // Filter history starts empty
      warm_cnt  <= '0;
      fir_valid <= 1'b0;
    end else begin
      if (accept) begin
        taps <= taps_nxt;  // Shift only on a real transfer, gaps keep the history
        if (!warm) begin
          warm_cnt <= warm_cnt + 1'b1;  // Saturates once the line is full
        end
      end
      if (accept && warm) begin
        fir_valid <= 1'b1;  // Fresh result loaded this edge
      end else if (fir_ready) begin
        fir_valid <= 1'b0;  // Result taken and nothing new behind it
      end
    end
  end

  // Output sample keeps the accumulator sign above bits 30 to 16
  always_ff @(posedge clk) begin
    if (accept && warm) begin
      fir_data <= {acc_nxt[`FAS_ACC_W-1], acc_nxt[`FAS_OUT_MSB:`FAS_OUT_LSB]};
    end
  end

endmodule

`default_nettype wire

// File: frame_buffer.sv
//*************************************************
// Serial-to-parallel frame buffer
// Collects 16 filtered samples in a fill register
// and hands each full frame to a hold register,
// so one frame fills while the previous one waits
//*************************************************
`timescale 1ns/1ps
`default_nettype none

`include "fas_params.svh"

module frame_buffer (
  input  logic             clk,
  input  logic             rst,
  input  logic             fir_valid,
  input  fas_pkg::sample_t fir_data,
  output logic             fir_ready,
  output logic             frame_valid,
  output fas_pkg::frame_t  frame_data,
  input  logic             frame_ready
);

  import fas_pkg::*;

  localparam int LEN   = `FAS_FRAME_LEN;
  localparam int CNT_W = $clog2(LEN);

  frame_t           fill_frame;  // Partial frame, samples 0 to 14 are used
  frame_t           done_frame;  // Fill register completed with the incoming sample
  logic [CNT_W-1:0] fill_cnt;    // Slot the next sample is written to
  logic             last;        // Next sample completes the frame
  logic             accept;      // Sample handshake completes this cycle
  logic             load;        // Full frame moves to the hold register

  assign last = (fill_cnt == CNT_W'(LEN - 1));

  // Stall only when the 16th sample has nowhere to go
  assign fir_ready = !(last && frame_valid);
  assign accept    = fir_valid && fir_ready;
  assign load      = accept && last;

  // Last slot comes straight from the input so the frame is complete
  // on the same edge the 16th sample arrives
  always_comb begin
    done_frame                   = fill_frame;
    done_frame.samples[LEN - 1] = fir_data;
  end

  // Fill position and hold register occupancy
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fill_cnt    <= '0;
      frame_valid <= 1'b0;
    end else begin
      if (accept) begin
        fill_cnt <= last ? '0 : fill_cnt + 1'b1;  // Wraps to start the next frame
      end
      if (load) begin
        frame_valid <= 1'b1;  // Hold register was free, checked through fir_ready
      end else if (frame_ready) begin
        frame_valid <= 1'b0;  // Frame taken by the sink
      end
    end
  end

  // Sample slots and the held frame
  always_ff @(posedge clk) begin
    if (accept && !last) begin
      fill_frame.samples[fill_cnt] <= fir_data;  // Slot 0 receives the oldest sample
    end
    if (load) begin
      frame_data <= done_frame;  // Stays put until frame_ready
    end
  end

endmodule

`default_nettype wire

// File: fas_top.sv
//*************************************************
// Filter and frame assembly top level
// FIR filter feeding the serial-to-parallel frame
// buffer over an internal valid/ready stream
//*************************************************
`timescale 1ns/1ps
`default_nettype none

module fas_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,     // Raw sample offered by the source
  input  fas_pkg::sample_t in_data,
  output logic             in_ready,
  output logic             frame_valid,  // Complete frame of filtered samples
  output fas_pkg::frame_t  frame_data,
  input  logic             frame_ready
);

  import fas_pkg::*;

  logic    fir_valid;  // Filtered sample available
  sample_t fir_data;   // Filtered sample
  logic    fir_ready;  // Frame buffer has room

  // Producer of the filtered stream
  fir_filter u_fir (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .fir_valid (fir_valid),
    .fir_data  (fir_data),
    .fir_ready (fir_ready)
  );

  // Groups filtered samples into frames of 16
  frame_buffer u_frame (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),
    .fir_data    (fir_data),
    .fir_ready   (fir_ready),
    .frame_valid (frame_valid),
    .frame_data  (frame_data),
    .frame_ready (frame_ready)
  );

endmodule

`default_nettype wire

// File: tb_fas.sv
//*************************************************
// Testbench for the FIR and frame assembly chain
// Applies a table of stimulus patterns, models the
// filter and framing, and checks every frame taken
//*************************************************
`timescale 1ns/1ps
`default_nettype none

`include "fas_params.svh"

module tb_fas;

  import fas_pkg::*;

  `include "fir_coeffs.svh"

  localparam int TIMEOUT_CYC = 500;  // Cycles without any transfer before giving up
  localparam int DRAIN_CYC   = 40;   // Quiet cycles watched for stray frames at the end
  localparam int NUM_TESTS   = 7;

  localparam int PAT_IMPULSE = 0;
  localparam int PAT_STEP    = 1;
  localparam int PAT_ALT     = 2;
  localparam int PAT_RANDOM  = 3;

  // One row of the stimulus table
  typedef struct packed {
    logic [8*12-1:0] name;      // Test name as packed characters
    int              pattern;   // Sample pattern and its in_valid gaps
    int              count;     // Samples offered to the DUT
    logic            throttle;  // Drive frame_ready from the LFSR
    int              frames;    // Frames the sink must receive
  } test_row_t;

  // Frame counts follow from count minus the 31 warm-up samples, over 16
  localparam test_row_t tests [NUM_TESTS] = '{
    '{"impulse",    PAT_IMPULSE, 63,  1'b0, 2},   // Impulse is the 32nd sample
    '{"warmup_46",  PAT_ALT,     46,  1'b0, 0},   // One output short of a frame
    '{"warmup_47",  PAT_ALT,     47,  1'b0, 1},   // First frame completes here
    '{"step",       PAT_STEP,    63,  1'b0, 2},
    '{"alt_thr",    PAT_ALT,     95,  1'b1, 4},
    '{"random",     PAT_RANDOM,  127, 1'b0, 6},
    '{"random_thr", PAT_RANDOM,  191, 1'b1, 10}
  };

  logic    clk;
  logic    rst;
  logic    in_valid;
  sample_t in_data;
  logic    in_ready;
  logic    frame_valid;
  frame_t  frame_data;
  logic    frame_ready;

  logic [31:0] lfsr_state;   // Shared random source, one step per bit taken
  sample_t     history [$];  // Every sample accepted since the last reset
  frame_t      exp_frames [$];  // Model frames not yet seen at the DUT
  frame_t      part_frame;   // Model frame being assembled
  int          part_cnt;     // Samples already in part_frame
  int          errors;
  int          checks;

  fas_top dut0 (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_data     (in_data),
    .in_ready    (in_ready),
    .frame_valid (frame_valid),
    .frame_data  (frame_data),
    .frame_ready (frame_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int unsigned take_bits(input int n);
    int unsigned bits;
    bits = 0;
    for (int i = 0; i < n; i++) begin
      bits       = (bits << 1) | lfsr_state[0];  // Output bit before the step
      lfsr_state = lfsr_next(lfsr_state);
    end
    return bits;
  endfunction

  function automatic sample_t pattern_value(input int pattern, input int idx);
    case (pattern)
      PAT_IMPULSE: return (idx == `FAS_TAPS - 1) ? sample_t'(16'sh4000) : sample_t'(0);
      PAT_STEP:    return sample_t'(16'sh1000);
      PAT_ALT:     return (idx % 2 == 0) ? sample_t'(16'sh2000) : sample_t'(-16'sh2000);
      default:     return sample_t'(take_bits(16));
    endcase
  endfunction

  // Alternating rows skip every 4th cycle, random rows about one in four
  function automatic logic take_gap(input int pattern, input int cyc);
    case (pattern)
      PAT_ALT:    return (cyc % 4 == 3);
      PAT_RANDOM: return (take_bits(2) == 0);
      default:    return 1'b0;
    endcase
  endfunction

  // Output at sample n is the sum of coeff k times the sample k older
  task automatic model_accept(input sample_t s);
    acc_t acc;
    int   n;
    history.push_back(s);
    n = history.size() - 1;
    if (history.size() >= `FAS_TAPS) begin
      acc = '0;
      for (int k = 0; k < `FAS_TAPS; k++) begin
        acc += acc_t'(fir_coeff[k]) * acc_t'(history[n - k]);
      end
      part_frame.samples[part_cnt] = {acc[`FAS_ACC_W-1], acc[`FAS_OUT_MSB:`FAS_OUT_LSB]};
      part_cnt++;
      if (part_cnt == `FAS_FRAME_LEN) begin
        exp_frames.push_back(part_frame);  // Oldest output sits in slot 0
        part_cnt = 0;
      end
    end
  endtask

  task automatic check_frame(input string name, input frame_t got, input frame_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %0h expected %0h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %0h expected %0h", name, got, exp);
    end
  endtask

  // Entered and left 2 ns after a rising edge
  task automatic apply_reset();
    rst         = 1'b1;
    in_valid    = 1'b0;
    in_data     = '0;
    frame_ready = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    history.delete();
    exp_frames.delete();
    part_frame = '0;
    part_cnt   = 0;
  endtask

  task automatic run_test(input test_row_t row);
    int   sent;
    int   frames_seen;
    int   idle;
    int   drain;
    int   cyc;
    int   errs_before;
    logic took;
    errs_before = errors;
    apply_reset();
    @(negedge clk);
    check_flag("frame_valid", frame_valid, 1'b0);  // Idle state right after reset
    check_flag("in_ready", in_ready, 1'b1);
    @(posedge clk);
    #2;
    sent        = 0;
    frames_seen = 0;
    idle        = 0;
    drain       = 0;
    cyc         = 0;
    while (drain < DRAIN_CYC && idle < TIMEOUT_CYC) begin
      if (!in_valid && sent < row.count && !take_gap(row.pattern, cyc)) begin
        in_valid = 1'b1;  // Held until the DUT takes it
        in_data  = pattern_value(row.pattern, sent);
      end
      // Throttled rows keep frame_ready low for 32 of every 64 cycles, long enough
      // for the next frame to fill behind a held one and stall the filter
      frame_ready = row.throttle ? (logic'(take_bits(1)) && (cyc % 64 < 32)) : 1'b1;
      @(negedge clk);  // Handshakes are decided by the coming edge
      idle++;
      took = in_valid && in_ready;
      if (took) begin
        model_accept(in_data);
        sent++;
        idle = 0;
      end
      if (frame_valid && frame_ready) begin
        if (exp_frames.size() == 0) begin
          errors++;
          $display("Test %0s received a frame that the model did not expect", row.name);
        end else begin
          check_frame("frame_data", frame_data, exp_frames.pop_front());
        end
        frames_seen++;
        idle = 0;
      end
      if (sent == row.count && exp_frames.size() == 0) begin
        drain++;  // Everything delivered, keep watching for extras
      end
      @(posedge clk);
      #2;
      if (took) begin
        in_valid = 1'b0;
      end
      cyc++;
    end
    if (idle >= TIMEOUT_CYC) begin
      errors++;
      $display("Test %0s timed out after %0d cycles without any transfer", row.name, idle);
    end
    in_valid = 1'b0;
    check_count("frame_count", frames_seen, row.frames);
    $display("Test %0s: %0s, %0d samples, %0d frames", row.name,
             (errors == errs_before) ? "ok" : "errors", sent, frames_seen);
  endtask

  initial begin
    rst         = 1'b1;
    in_valid    = 1'b0;
    in_data     = '0;
    frame_ready = 1'b0;
    lfsr_state  = 32'h2134;
    errors      = 0;
    checks      = 0;
    part_frame  = '0;
    part_cnt    = 0;
    @(posedge clk);
    #2;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(tests[t]);
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
fas_pkg.sv
fir_filter.sv
frame_buffer.sv
fas_top.sv
tb_fas.sv
